// File: dcache_cfg.svh
/*
 * width and size macros for the direct-mapped data cache
 */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// processor side
`define DC_WORD_W      32
`define DC_ADDR_W      30

// memory side with four words per block
`define DC_BLOCK_W     128
`define DC_MEM_ADDR_W  28

// word address split into tag, index and offset
`define DC_OFFSET_W    2
`define DC_INDEX_W     3
`define DC_TAG_W       25

// line count
`define DC_LINES       8

`endif

// File: dcache_pkg.sv
/*
 * data cache package: processor request, memory request,
 * stored line and line update types
 */
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    ////////////////////
    // bus requests
    ////////////////////

    // read and write strobes with a word address
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`DC_ADDR_W-1:0]     addr;
        logic [`DC_WORD_W-1:0]     wdata;
    } proc_req_t;

    // block access to the slow memory
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [`DC_MEM_ADDR_W-1:0] addr;
        logic [`DC_BLOCK_W-1:0]    wdata;
    } mem_req_t;

    ////////////////////
    // line storage
    ////////////////////

    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [`DC_TAG_W-1:0]      tag;
        logic [`DC_BLOCK_W-1:0]    data;
    } line_t;

    // applies to the line picked by the request index
    typedef struct packed {
        logic                      data_we;
        logic                      tag_we;
        logic                      set_valid;
        logic                      set_dirty;
        logic                      clear_dirty;
        logic [`DC_TAG_W-1:0]      tag;
        logic [`DC_BLOCK_W-1:0]    data;
    } line_upd_t;

endpackage

`default_nettype wire

// File: dcache_line_store.sv
/*
 * line store: valid, dirty, tag and data arrays for all lines,
 * indexed read and merged update
 */
`default_nettype none

`include "dcache_cfg.svh"

module dcache_line_store
    import dcache_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`DC_INDEX_W-1:0] index_i,
    input  line_upd_t                   hit_upd_i,
    input  line_upd_t                   fill_upd_i,
    output line_t                       line_o
);

    logic [`DC_LINES-1:0]   valid_q;
    logic [`DC_LINES-1:0]   dirty_q;
    logic [`DC_TAG_W-1:0]   tag_q  [`DC_LINES];
    logic [`DC_BLOCK_W-1:0] data_q [`DC_LINES];
    line_upd_t              upd;

    ////////////////////
    // update merge
    ////////////////////

    // hit and fill are exclusive, so enables simply combine
    // only a refill brings a new tag
    always_comb begin
        upd.data_we     = hit_upd_i.data_we | fill_upd_i.data_we;
        upd.tag_we      = hit_upd_i.tag_we | fill_upd_i.tag_we;
        upd.set_valid   = hit_upd_i.set_valid | fill_upd_i.set_valid;
        upd.set_dirty   = hit_upd_i.set_dirty | fill_upd_i.set_dirty;
        upd.clear_dirty = hit_upd_i.clear_dirty | fill_upd_i.clear_dirty;
        upd.tag         = fill_upd_i.tag;
        upd.data        = fill_upd_i.data_we ? fill_upd_i.data : hit_upd_i.data;
    end

    ////////////////////
    // state bits
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (upd.set_valid) begin
                valid_q[index_i] <= 1'b1;
            end
            // a write hit wins over a clear
            if (upd.set_dirty) begin
                dirty_q[index_i] <= 1'b1;
            end else if (upd.clear_dirty) begin
                dirty_q[index_i] <= 1'b0;
            end
        end
    end

    // tag and block payload
    always_ff @(posedge clk) begin
        if (upd.tag_we) begin
            tag_q[index_i] <= upd.tag;
        end
        if (upd.data_we) begin
            data_q[index_i] <= upd.data;
        end
    end

    // indexed line straight from the registers
    always_comb begin
        line_o.valid = valid_q[index_i];
        line_o.dirty = dirty_q[index_i];
        line_o.tag   = tag_q[index_i];
        line_o.data  = data_q[index_i];
    end

endmodule

`default_nettype wire

// File: dcache_lookup.sv
/*
 * processor-side lookup: tag compare, hit/miss and stall,
 * read word select and write-hit word merge
 */
`default_nettype none

`include "dcache_cfg.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  proc_req_t                proc_req_i,
    input  line_t                    line_i,
    output logic [`DC_INDEX_W-1:0]   index_o,
    output logic                     miss_o,
    output line_upd_t                hit_upd_o,
    output logic [`DC_WORD_W-1:0]    proc_rdata_o,
    output logic                     proc_stall_o
);

    localparam int IDX_LO = `DC_OFFSET_W;
    localparam int TAG_LO = `DC_OFFSET_W + `DC_INDEX_W;

    logic                    access;
    logic                    hit;
    logic [`DC_OFFSET_W-1:0] offset;
    logic [`DC_TAG_W-1:0]    req_tag;
    logic [`DC_BLOCK_W-1:0]  merged;

    ////////////////////
    // address split
    ////////////////////

    assign offset  = proc_req_i.addr[IDX_LO-1:0];
    assign index_o = proc_req_i.addr[TAG_LO-1:IDX_LO];
    assign req_tag = proc_req_i.addr[`DC_ADDR_W-1:TAG_LO];

    ////////////////////
    // hit and stall
    ////////////////////

    assign access = proc_req_i.read | proc_req_i.write;
    assign hit    = line_i.valid && (line_i.tag == req_tag);

    // no request means no stall
    assign miss_o       = access && !hit;
    assign proc_stall_o = miss_o;

    // read hit returns the word in the same cycle
    always_comb begin
        proc_rdata_o = '0;
        if (hit && proc_req_i.read) begin
            proc_rdata_o = line_i.data[offset*`DC_WORD_W +: `DC_WORD_W];
        end
    end

    // replace one word, keep the other three
    always_comb begin
        merged = line_i.data;
        merged[offset*`DC_WORD_W +: `DC_WORD_W] = proc_req_i.wdata;
    end

    ////////////////////
    // write hit
    ////////////////////

    always_comb begin
        hit_upd_o      = '0;
        hit_upd_o.data = merged;
        if (hit && proc_req_i.write) begin
            hit_upd_o.data_we   = 1'b1;
            hit_upd_o.set_dirty = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: dcache_miss_ctrl.sv
/*
 * miss controller: dirty victim writeback, block refill,
 * line updates on mem_ready
 */
`default_nettype none

`include "dcache_cfg.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  wire logic                   miss_i,
    input  wire logic [`DC_ADDR_W-1:0]  req_addr_i,
    input  line_t                       line_i,
    input  wire logic [`DC_BLOCK_W-1:0] mem_rdata_i,
    input  wire logic                   mem_ready_i,
    output mem_req_t                    mem_req_o,
    output line_upd_t                   fill_upd_o
);

    localparam int TAG_LO = `DC_OFFSET_W + `DC_INDEX_W;

    logic [`DC_INDEX_W-1:0]    index;
    logic [`DC_TAG_W-1:0]      req_tag;
    logic [`DC_MEM_ADDR_W-1:0] req_block;
    logic [`DC_MEM_ADDR_W-1:0] victim_block;

    ////////////////////
    // block addresses
    ////////////////////

    assign index        = req_addr_i[TAG_LO-1:`DC_OFFSET_W];
    assign req_tag      = req_addr_i[`DC_ADDR_W-1:TAG_LO];
    assign req_block    = req_addr_i[`DC_ADDR_W-1:`DC_OFFSET_W];
    assign victim_block = {line_i.tag, index};

    ////////////////////
    // miss sequencing
    ////////////////////

    // the victim dirty bit picks the phase with writeback first
    // and refill once the dirty bit has cleared
    always_comb begin
        mem_req_o       = '0;
        fill_upd_o      = '0;
        fill_upd_o.tag  = req_tag;
        fill_upd_o.data = mem_rdata_i;
        if (miss_i) begin
            if (line_i.dirty) begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = victim_block;
                mem_req_o.wdata = line_i.data;
                // victim now matches memory
                fill_upd_o.clear_dirty = mem_ready_i;
            end else begin
                mem_req_o.read = 1'b1;
                mem_req_o.addr = req_block;
                // block is on mem_rdata_i in the ready cycle
                fill_upd_o.data_we   = mem_ready_i;
                fill_upd_o.tag_we    = mem_ready_i;
                fill_upd_o.set_valid = mem_ready_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
/*
 * direct-mapped write-back data cache, top level
 */
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // processor side
    input  proc_req_t                   proc_req_i,
    output logic [`DC_WORD_W-1:0]       proc_rdata_o,
    output logic                        proc_stall_o,
    // memory side
    output mem_req_t                    mem_req_o,
    input  wire logic [`DC_BLOCK_W-1:0] mem_rdata_i,
    input  wire logic                   mem_ready_i
);

    logic [`DC_INDEX_W-1:0] index;
    logic                   miss;
    line_t                  cur_line;
    line_upd_t              hit_upd;
    line_upd_t              fill_upd;

    // processor-side tag check and hit handling
    dcache_lookup u_lookup (
        .proc_req_i   (proc_req_i),
        .line_i       (cur_line),
        .index_o      (index),
        .miss_o       (miss),
        .hit_upd_o    (hit_upd),
        .proc_rdata_o (proc_rdata_o),
        .proc_stall_o (proc_stall_o)
    );

    dcache_line_store u_line_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .index_i    (index),
        .hit_upd_i  (hit_upd),
        .fill_upd_i (fill_upd),
        .line_o     (cur_line)
    );

    // writeback and refill toward memory
    dcache_miss_ctrl u_miss_ctrl (
        .miss_i      (miss),
        .req_addr_i  (proc_req_i.addr),
        .line_i      (cur_line),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i),
        .mem_req_o   (mem_req_o),
        .fill_upd_o  (fill_upd)
    );

endmodule

`default_nettype wire

// File: tb_slow_mem.sv
/*
 * testbench memory: 256 blocks of four words with a
 * fixed-latency ready pulse and a write-back counter
 */
`default_nettype none

`include "dcache_cfg.svh"

module tb_slow_mem
    import dcache_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  mem_req_t                    mem_req_i,
    output logic [`DC_BLOCK_W-1:0]      mem_rdata_o,
    output logic                        mem_ready_o,
    output logic [15:0]                 wb_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 4;

    logic [`DC_WORD_W-1:0] mem_words [1024];
    logic [7:0]            blk;
    logic [2:0]            wait_cnt;

    // 256 blocks with the upper block address bits ignored
    assign blk = mem_req_i.addr[7:0];

    // word 0 sits in the low bits of the block
    assign mem_rdata_o = {mem_words[{blk, 2'd3}], mem_words[{blk, 2'd2}],
                          mem_words[{blk, 2'd1}], mem_words[{blk, 2'd0}]};

    ////////////////////
    // latency counter
    ////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt    <= '0;
            mem_ready_o <= 1'b0;
            wb_count_o  <= '0;
        end else begin
            mem_ready_o <= 1'b0;
            if ((mem_req_i.read || mem_req_i.write) && !mem_ready_o) begin
                if (wait_cnt == 3'(LATENCY - 1)) begin
                    mem_ready_o <= 1'b1;
                    wait_cnt    <= '0;
                end else begin
                    wait_cnt <= wait_cnt + 3'd1;
                end
            end else begin
                wait_cnt <= '0;
            end
            if (mem_ready_o && mem_req_i.write) begin
                wb_count_o <= wb_count_o + 16'd1;
            end
        end
    end

    // block write lands on the ready pulse
    always @(posedge clk) begin
        if (mem_ready_o && mem_req_i.write) begin
            mem_words[{blk, 2'd0}] = mem_req_i.wdata[31:0];
            mem_words[{blk, 2'd1}] = mem_req_i.wdata[63:32];
            mem_words[{blk, 2'd2}] = mem_req_i.wdata[95:64];
            mem_words[{blk, 2'd3}] = mem_req_i.wdata[127:96];
        end
    end

endmodule

`default_nettype wire

// File: tb_dcache.sv
/*
 * data cache testbench: stimulus table with expected values,
 * shadow memory and line model, checks and watchdog
 */
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int N_ENTRIES      = 64;
    localparam int MEM_WORDS      = 1024;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ENTRIES * 20 + 10;

    // one table row holds the request and what the cache must do with it
    typedef struct packed {
        logic                      write;
        logic [`DC_ADDR_W-1:0]     addr;
        logic [`DC_WORD_W-1:0]     wdata;
        logic [`DC_WORD_W-1:0]     exp_rdata;
        logic                      exp_hit;
        logic                      exp_wb;
        logic [`DC_MEM_ADDR_W-1:0] wb_addr;
        logic [`DC_BLOCK_W-1:0]    wb_data;
    } entry_t;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    proc_req_t              proc_req;
    logic [`DC_WORD_W-1:0]  proc_rdata;
    logic                   proc_stall;
    mem_req_t               mem_req;
    logic [`DC_BLOCK_W-1:0] mem_rdata;
    logic                   mem_ready;
    logic [15:0]            wb_count;

    entry_t                 stim_tab [$];
    logic [`DC_WORD_W-1:0]  shadow [MEM_WORDS];
    logic                   model_valid [`DC_LINES];
    logic                   model_dirty [`DC_LINES];
    logic [`DC_TAG_W-1:0]   model_tag [`DC_LINES];
    int                     n_checks = 0;
    int                     n_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top u_dcache_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_req_i   (proc_req),
        .proc_rdata_o (proc_rdata),
        .proc_stall_o (proc_stall),
        .mem_req_o    (mem_req),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    tb_slow_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req_i   (mem_req),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready),
        .wb_count_o  (wb_count)
    );

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] got_v);
        $display("FAIL t=%0d ns %s expected %h got %h", $time, name, exp_v, got_v);
        n_errors++;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // direct-mapped, write-back, write-allocate
    task automatic add_entry(input logic wr, input logic [`DC_ADDR_W-1:0] addr,
                             input logic [`DC_WORD_W-1:0] wdata);
        entry_t                 e;
        logic [`DC_INDEX_W-1:0] idx;
        logic [`DC_TAG_W-1:0]   tag;
        logic [7:0]             blk;
        e         = '0;
        idx       = addr[4:2];
        tag       = addr[29:5];
        e.write   = wr;
        e.addr    = addr;
        e.wdata   = wdata;
        e.exp_hit = model_valid[idx] && (model_tag[idx] == tag);
        if (!e.exp_hit) begin
            if (model_valid[idx] && model_dirty[idx]) begin
                e.exp_wb  = 1'b1;
                e.wb_addr = {model_tag[idx], idx};
                blk       = e.wb_addr[7:0];
                e.wb_data = {shadow[{blk, 2'd3}], shadow[{blk, 2'd2}],
                             shadow[{blk, 2'd1}], shadow[{blk, 2'd0}]};
            end
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            model_dirty[idx] = 1'b0;
        end
        if (wr) begin
            shadow[addr[9:0]] = wdata;
            model_dirty[idx]  = 1'b1;
        end else begin
            e.exp_rdata = shadow[addr[9:0]];
        end
        stim_tab.push_back(e);
    endtask

    task automatic build_table();
        // cold miss then hit, write hit with its neighbours
        add_entry(1'b0, 30'h005, '0);
        add_entry(1'b0, 30'h005, '0);
        add_entry(1'b1, 30'h006, 32'h1234_5678);
        add_entry(1'b0, 30'h006, '0);
        add_entry(1'b0, 30'h004, '0);
        add_entry(1'b0, 30'h005, '0);
        add_entry(1'b0, 30'h007, '0);
        // same index, other tag, so the dirty line goes back
        add_entry(1'b0, 30'h025, '0);
        add_entry(1'b0, 30'h006, '0);
        // clean conflicts on index 2
        add_entry(1'b0, 30'h028, '0);
        add_entry(1'b0, 30'h008, '0);
        add_entry(1'b0, 30'h028, '0);
        // random mix over 64 words
        while (stim_tab.size() < N_ENTRIES) begin
            add_entry($urandom_range(1, 0) == 1, 30'($urandom_range(63, 0)), $urandom);
        end
    endtask

    ////////////////////
    // apply and check
    ////////////////////

    // starts 5 ns after an edge, returns 5 ns after the edge that completes the access
    task automatic apply_entry(input entry_t e);
        logic                   first_stall;
        logic [15:0]            wb_before;
        logic [7:0]             blk;
        logic [`DC_BLOCK_W-1:0] mem_block;
        proc_req.read  = !e.write;
        proc_req.write = e.write;
        proc_req.addr  = e.addr;
        proc_req.wdata = e.wdata;
        wb_before      = wb_count;
        #(CLK_PERIOD - 20);
        first_stall = proc_stall;
        while (proc_stall) begin
            @(posedge clk);
            #(CLK_PERIOD - 15);
        end
        n_checks++;
        if (first_stall !== !e.exp_hit) begin
            report_mismatch("proc_stall_o", 128'(!e.exp_hit), 128'(first_stall));
        end
        if (!e.write) begin
            n_checks++;
            if (proc_rdata !== e.exp_rdata) begin
                report_mismatch("proc_rdata_o", 128'(e.exp_rdata), 128'(proc_rdata));
            end
        end
        n_checks++;
        if (wb_count - wb_before !== 16'(e.exp_wb)) begin
            report_mismatch("wb_count_o", 128'(e.exp_wb), 128'(wb_count - wb_before));
        end
        if (e.exp_wb) begin
            blk       = e.wb_addr[7:0];
            mem_block = {u_mem.mem_words[{blk, 2'd3}], u_mem.mem_words[{blk, 2'd2}],
                         u_mem.mem_words[{blk, 2'd1}], u_mem.mem_words[{blk, 2'd0}]};
            n_checks++;
            if (mem_block !== e.wb_data) begin
                report_mismatch("u_mem.mem_words", e.wb_data, mem_block);
            end
        end
        @(posedge clk);
        #5;
    endtask

    initial begin
        proc_req = '0;
        void'($urandom(32'hee67_c5d4));
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]          = $urandom;
            u_mem.mem_words[i] = shadow[i];
        end
        for (int i = 0; i < `DC_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i]   = '0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;
        #(CLK_PERIOD - 20);
        // idle after reset
        n_checks++;
        if ({proc_stall, mem_req.read, mem_req.write} !== 3'b000) begin
            report_mismatch("proc_stall_o/mem_req_o.read/mem_req_o.write", 128'(0),
                            128'({proc_stall, mem_req.read, mem_req.write}));
        end
        @(posedge clk);
        #5;
        for (int i = 0; i < stim_tab.size(); i++) begin
            apply_entry(stim_tab[i]);
        end
        proc_req = '0;
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog sized for the worst-case miss per entry
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the cache kept stalling past %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
dcache_pkg.sv
dcache_line_store.sv
dcache_lookup.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_slow_mem.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_dcache -f list.f -o tb_dcache_sim

./obj_dir/tb_dcache_sim > sim.log
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
